// File: files.f
rtl/pkg_tpu.sv
rtl/ma_unit.sv
rtl/div_unit.sv
rtl/srl_unit.sv
rtl/alu.sv
verification/tb_alu.sv

// File: rtl/alu.sv
// Execution lane top
// Decodes and issues one command per cycle to the multiply-add, divide or
// shift unit, then writes back the oldest finished result first

module alu #(
	parameter int DEPTH_MLT		= 3
)(
	input	logic							clock,
	input	logic							rst_n,
	input	logic							req,		// Command present
	input	logic							stall,		// Hold acceptance
	input	pkg_tpu::op_t					op,
	input	logic [pkg_tpu::DST_W-1:0]		dst,
	input	logic [pkg_tpu::DATA_W-1:0]		src1,
	input	logic [pkg_tpu::DATA_W-1:0]		src2,
	input	logic [pkg_tpu::DATA_W-1:0]		src3,
	output	logic							busy,
	output	logic							done,
	output	logic [pkg_tpu::DST_W-1:0]		wb_dst,
	output	pkg_tpu::issue_no_t				wb_issue_no,
	output	logic [pkg_tpu::DATA_W-1:0]		wb_data
);

	logic						tgt_ma;
	logic						tgt_div;
	logic						tgt_srl;
	logic						accept;
	pkg_tpu::issue_no_t			issue_cnt;

	logic						ma_ready,	div_ready,	srl_ready;
	logic						ma_valid,	div_valid,	srl_valid;
	logic						take_ma,	take_div,	take_srl;
	logic [pkg_tpu::DST_W-1:0]	ma_dst,		div_dst,	srl_dst;
	pkg_tpu::issue_no_t			ma_ino,		div_ino,	srl_ino;
	pkg_tpu::issue_no_t			age_ma,		age_div,	age_srl;
	pkg_tpu::alu_word_u			ma_data;
	logic [pkg_tpu::DATA_W-1:0]	div_data;
	logic [pkg_tpu::DATA_W-1:0]	srl_data;
	logic						ma_gt_div;
	logic						ma_gt_srl;
	logic						div_gt_srl;

	//////////////////////////////////////////////////////////////////////
	// Decode and issue
	//////////////////////////////////////////////////////////////////////
	assign tgt_ma	= (op.op_type == pkg_tpu::ARITH) &
					  ((op.op_class == pkg_tpu::ADD) | (op.op_class == pkg_tpu::MULADD));
	assign tgt_div	= (op.op_type == pkg_tpu::ARITH) &
					  ((op.op_class == pkg_tpu::DIV) | (op.op_class == pkg_tpu::REM));
	assign tgt_srl	= (op.op_type == pkg_tpu::SHIFT);

	// Target unit cannot take an operand
	assign busy		= (tgt_ma & ~ma_ready) | (tgt_div & ~div_ready) | (tgt_srl & ~srl_ready);

	// Reserved op types fall through unaccepted
	assign accept	= req & ~stall & ~busy & (tgt_ma | tgt_div | tgt_srl);

	always_ff @(posedge clock) begin
		if (!rst_n)
			issue_cnt <= '0;
		else if (accept)
			issue_cnt <= issue_cnt + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Oldest-first write-back
	//////////////////////////////////////////////////////////////////////
	assign age_ma		= issue_cnt - ma_ino;
	assign age_div		= issue_cnt - div_ino;
	assign age_srl		= issue_cnt - srl_ino;

	assign ma_gt_div	= age_ma > age_div;
	assign ma_gt_srl	= age_ma > age_srl;
	assign div_gt_srl	= age_div > age_srl;

	assign take_ma	= ma_valid & (~div_valid | ma_gt_div) & (~srl_valid | ma_gt_srl);
	assign take_div	= div_valid & (~ma_valid | ~ma_gt_div) & (~srl_valid | div_gt_srl);
	assign take_srl	= srl_valid & (~ma_valid | ~ma_gt_srl) & (~div_valid | ~div_gt_srl);

	assign done		= take_ma | take_div | take_srl;

	always_comb begin
		wb_dst		= ma_dst;
		wb_issue_no	= ma_ino;
		wb_data		= ma_data;
		if (take_div) begin
			wb_dst		= div_dst;
			wb_issue_no	= div_ino;
			wb_data		= div_data;
		end else if (take_srl) begin
			wb_dst		= srl_dst;
			wb_issue_no	= srl_ino;
			wb_data		= srl_data;
		end
	end

	a_take_onehot: assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0({take_ma, take_div, take_srl}) &&
		(!take_ma || ma_valid) && (!take_div || div_valid) && (!take_srl || srl_valid));

	//////////////////////////////////////////////////////////////////////
	// Function units
	//////////////////////////////////////////////////////////////////////
	ma_unit #(
		.DEPTH_MLT		(DEPTH_MLT)
	) u_ma (
		.clock			(clock),
		.rst_n			(rst_n),
		.start			(accept & tgt_ma),
		.op				(op),
		.dst			(dst),
		.issue_no		(issue_cnt),
		.a				(src1),
		.b				(src2),
		.c				(src3),
		.take			(take_ma),
		.ready_in		(ma_ready),
		.valid			(ma_valid),
		.res_dst		(ma_dst),
		.res_issue_no	(ma_ino),
		.res_data		(ma_data)
	);

	div_unit u_div (
		.clock			(clock),
		.rst_n			(rst_n),
		.start			(accept & tgt_div),
		.op				(op),
		.dst			(dst),
		.issue_no		(issue_cnt),
		.a				(src1),
		.b				(src2),
		.take			(take_div),
		.ready_in		(div_ready),
		.valid			(div_valid),
		.res_dst		(div_dst),
		.res_issue_no	(div_ino),
		.res_data		(div_data)
	);

	srl_unit u_srl (
		.clock			(clock),
		.rst_n			(rst_n),
		.start			(accept & tgt_srl),
		.op				(op),
		.dst			(dst),
		.issue_no		(issue_cnt),
		.a				(src1),
		.b				(src2),
		.take			(take_srl),
		.ready_in		(srl_ready),
		.valid			(srl_valid),
		.res_dst		(srl_dst),
		.res_issue_no	(srl_ino),
		.res_data		(srl_data)
	);

endmodule

// File: rtl/div_unit.sv
// Iterative integer divider
// Restoring radix-2 shift-subtract over 32 cycles, unsigned quotient or
// remainder into a result holding register

module div_unit (
	input	logic							clock,
	input	logic							rst_n,
	input	logic							start,
	input	pkg_tpu::op_t					op,
	input	logic [pkg_tpu::DST_W-1:0]		dst,
	input	pkg_tpu::issue_no_t				issue_no,
	input	logic [pkg_tpu::DATA_W-1:0]		a,
	input	logic [pkg_tpu::DATA_W-1:0]		b,
	input	logic							take,
	output	logic							ready_in,
	output	logic							valid,
	output	logic [pkg_tpu::DST_W-1:0]		res_dst,
	output	pkg_tpu::issue_no_t				res_issue_no,
	output	logic [pkg_tpu::DATA_W-1:0]		res_data
);

	localparam int W		= pkg_tpu::DATA_W;
	localparam int CNT_W	= $clog2(W);

	logic					run;				// Iterating
	logic [CNT_W-1:0]		cnt;
	logic					last;
	logic [W-1:0]			rem;
	logic [W-1:0]			quot;
	logic [W-1:0]			dvd;				// Original dividend
	logic [W-1:0]			dvs;
	logic					is_rem;
	logic [W:0]				shifted;
	logic [W:0]				diff;
	logic [W-1:0]			rem_nx;
	logic [W-1:0]			quot_nx;

	// One division at a time, held until written back
	assign ready_in	= ~run & ~valid;
	assign last		= run & (cnt == CNT_W'(W - 1));

	//////////////////////////////////////////////////////////////////////
	// One restoring step
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		shifted	= {rem, quot[W-1]};
		diff	= shifted - {1'b0, dvs};
		if (diff[W]) begin						// Borrow, restore
			rem_nx	= shifted[W-1:0];
			quot_nx	= {quot[W-2:0], 1'b0};
		end else begin
			rem_nx	= diff[W-1:0];
			quot_nx	= {quot[W-2:0], 1'b1};
		end
	end

	// Control
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			run		<= 1'b0;
			cnt		<= '0;
			valid	<= 1'b0;
		end else begin
			if (start) begin
				run	<= 1'b1;
				cnt	<= '0;
			end else if (run) begin
				cnt	<= cnt + 1'b1;
				if (last) begin
					run		<= 1'b0;
					valid	<= 1'b1;
				end
			end
			if (take)
				valid <= 1'b0;
		end
	end

	// Working registers
	always_ff @(posedge clock) begin
		if (start) begin
			rem		<= '0;
			quot	<= a;
			dvd		<= a;
			dvs		<= b;
			is_rem	<= (op.op_class == pkg_tpu::REM);
			res_dst			<= dst;
			res_issue_no	<= issue_no;
		end else if (run) begin
			rem		<= rem_nx;
			quot	<= quot_nx;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Holding register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (last) begin
			if (dvs == '0)
				res_data <= is_rem ? dvd : pkg_tpu::DIV_ZERO_Q;
			else
				res_data <= is_rem ? rem_nx : quot_nx;
		end
	end

	// A finished result and a running division never coexist
	a_valid_run: assert property (@(posedge clock) disable iff (!rst_n)
		!(valid && run));

endmodule

// File: rtl/ma_unit.sv
// Multiply-add unit
// DEPTH_MLT multiplier stages, an add stage and one result holding register.
// Full 32-bit or dual 16-bit multiply-add, plus plain ADD through the same pipe

module ma_unit #(
	parameter int DEPTH_MLT		= 3
)(
	input	logic						clock,
	input	logic						rst_n,
	input	logic						start,
	input	pkg_tpu::op_t				op,
	input	logic [pkg_tpu::DST_W-1:0]	dst,
	input	pkg_tpu::issue_no_t			issue_no,
	input	pkg_tpu::alu_word_u			a,
	input	pkg_tpu::alu_word_u			b,
	input	pkg_tpu::alu_word_u			c,
	input	logic						take,
	output	logic						ready_in,
	output	logic						valid,
	output	logic [pkg_tpu::DST_W-1:0]	res_dst,
	output	pkg_tpu::issue_no_t			res_issue_no,
	output	pkg_tpu::alu_word_u			res_data
);

	localparam int LAST = DEPTH_MLT - 1;

	logic						advance;
	pkg_tpu::alu_word_u			prd_in;
	pkg_tpu::alu_word_u			adn_in;
	pkg_tpu::alu_word_u			sum;

	// Multiplier pipe
	logic						stg_v		[DEPTH_MLT];
	logic						stg_simd	[DEPTH_MLT];
	pkg_tpu::alu_word_u			stg_prd		[DEPTH_MLT];
	pkg_tpu::alu_word_u			stg_adn		[DEPTH_MLT];
	logic [pkg_tpu::DST_W-1:0]	stg_dst		[DEPTH_MLT];
	pkg_tpu::issue_no_t			stg_ino		[DEPTH_MLT];

	// Whole pipe moves only when the holding register can accept
	assign advance	= ~valid | take;
	assign ready_in	= advance;

	//////////////////////////////////////////////////////////////////////
	// Product and addend selection
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		prd_in = a;								// ADD skips the multiplier
		adn_in = b;
		if (op.op_class == pkg_tpu::MULADD) begin
			adn_in = c;
			if (op.simd) begin
				prd_in.half.hi = a.half.hi * b.half.hi;	// Each lane wraps to 16 bits
				prd_in.half.lo = a.half.lo * b.half.lo;
			end else begin
				prd_in.word = a.word * b.word;
			end
		end
	end

	// Stage valid flags
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH_MLT; i++)
				stg_v[i] <= 1'b0;
		end else if (advance) begin
			stg_v[0] <= start;
			for (int i = 1; i < DEPTH_MLT; i++)
				stg_v[i] <= stg_v[i-1];
		end
	end

	// Stage payload, retimed across the multiplier by synthesis
	always_ff @(posedge clock) begin
		if (advance) begin
			stg_prd[0]	<= prd_in;
			stg_adn[0]	<= adn_in;
			stg_simd[0]	<= op.simd;
			stg_dst[0]	<= dst;
			stg_ino[0]	<= issue_no;
			for (int i = 1; i < DEPTH_MLT; i++) begin
				stg_prd[i]	<= stg_prd[i-1];
				stg_adn[i]	<= stg_adn[i-1];
				stg_simd[i]	<= stg_simd[i-1];
				stg_dst[i]	<= stg_dst[i-1];
				stg_ino[i]	<= stg_ino[i-1];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Add stage and holding register
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		if (stg_simd[LAST]) begin
			sum.half.hi = stg_prd[LAST].half.hi + stg_adn[LAST].half.hi;
			sum.half.lo = stg_prd[LAST].half.lo + stg_adn[LAST].half.lo;
		end else begin
			sum.word = stg_prd[LAST].word + stg_adn[LAST].word;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			valid <= 1'b0;
		else if (advance)
			valid <= stg_v[LAST];			// Empties on take unless a result follows
	end

	always_ff @(posedge clock) begin
		if (advance && stg_v[LAST]) begin
			res_data		<= sum;
			res_dst			<= stg_dst[LAST];
			res_issue_no	<= stg_ino[LAST];
		end
	end

	// Lane must not dispatch into a frozen pipe
	a_start_ready: assert property (@(posedge clock) disable iff (!rst_n)
		start |-> ready_in);

endmodule

// File: rtl/pkg_tpu.sv
// Tensor-processor lane package
// Widths, opcode fields, the dual-view operand word and the issue number

package pkg_tpu;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////
	localparam int DATA_W	= 32;		// Operand width
	localparam int ISSUE_W	= 8;		// Issue number width
	localparam int DST_W	= 6;		// Destination register index
	localparam int HALF_W	= DATA_W / 2;
	localparam int SHAMT_W	= 5;		// Shift amount taken from src2

	// Issue number, counts up per accepted command and wraps
	typedef logic [ISSUE_W-1:0]		issue_no_t;

	//////////////////////////////////////////////////////////////////////
	// Opcode fields
	//////////////////////////////////////////////////////////////////////
	typedef logic [1:0]				op_type_t;
	typedef logic [1:0]				op_class_t;

	localparam op_type_t	ARITH	= 2'b00;
	localparam op_type_t	SHIFT	= 2'b10;	// 01 and 11 are reserved

	// Arithmetic classes
	localparam op_class_t	ADD		= 2'b00;	// a + b
	localparam op_class_t	MULADD	= 2'b01;	// a * b + c
	localparam op_class_t	DIV		= 2'b10;	// Unsigned a / b
	localparam op_class_t	REM		= 2'b11;	// Unsigned a mod b

	// Shift classes
	localparam op_class_t	SLL		= 2'b00;
	localparam op_class_t	SRL		= 2'b01;
	localparam op_class_t	SRA		= 2'b10;
	localparam op_class_t	ROR		= 2'b11;

	// Decoded operation, 5 bits
	typedef struct packed {
		op_type_t	op_type;
		op_class_t	op_class;
		logic		simd;		// Dual 16-bit mode for the multiply-add unit
	} op_t;

	//////////////////////////////////////////////////////////////////////
	// Operand word
	//////////////////////////////////////////////////////////////////////
	// One 32-bit word, read as a single integer or as two 16-bit lanes
	typedef union packed {
		logic signed [DATA_W-1:0]	word;
		struct packed {
			logic signed [HALF_W-1:0]	hi;
			logic signed [HALF_W-1:0]	lo;
		} half;
	} alu_word_u;

	// Divide by zero returns an all-ones quotient
	localparam logic [DATA_W-1:0]	DIV_ZERO_Q	= '1;

endpackage

// File: rtl/srl_unit.sv
// Shift and rotate unit
// Single-cycle barrel shifter for SLL, SRL, SRA and ROR into a holding register

module srl_unit (
	input	logic							clock,
	input	logic							rst_n,
	input	logic							start,
	input	pkg_tpu::op_t					op,
	input	logic [pkg_tpu::DST_W-1:0]		dst,
	input	pkg_tpu::issue_no_t				issue_no,
	input	logic [pkg_tpu::DATA_W-1:0]		a,
	input	logic [pkg_tpu::DATA_W-1:0]		b,
	input	logic							take,
	output	logic							ready_in,
	output	logic							valid,
	output	logic [pkg_tpu::DST_W-1:0]		res_dst,
	output	pkg_tpu::issue_no_t				res_issue_no,
	output	logic [pkg_tpu::DATA_W-1:0]		res_data
);

	localparam int W = pkg_tpu::DATA_W;

	logic [pkg_tpu::SHAMT_W-1:0]	amt;
	logic [2*W-1:0]					rot;
	logic [W-1:0]					sh;

	assign ready_in	= ~valid | take;			// Take and refill in one cycle
	assign amt		= b[pkg_tpu::SHAMT_W-1:0];
	assign rot		= {a, a} >> amt;

	always_comb begin
		case (op.op_class)
			pkg_tpu::SLL:	sh = a << amt;
			pkg_tpu::SRL:	sh = a >> amt;
			pkg_tpu::SRA:	sh = $signed(a) >>> amt;
			default:		sh = rot[W-1:0];		// ROR
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			valid <= 1'b0;
		else if (start)
			valid <= 1'b1;
		else if (take)
			valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (start) begin
			res_data		<= sh;
			res_dst			<= dst;
			res_issue_no	<= issue_no;
		end
	end

	a_start_ready: assert property (@(posedge clock) disable iff (!rst_n)
		start |-> ready_in);

endmodule

// File: verification/tb_alu.sv
// Execution lane testbench
// Directed tests for multiply-add, divide, shift, oldest-first write-back,
// stall and reset, checked against a reference model of the lane rules

module tb_alu;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_TESTS	= 6;
	localparam int W		= pkg_tpu::DATA_W;
	localparam int N_INO	= 2 ** pkg_tpu::ISSUE_W;

	logic							clock;
	logic							rst_n;
	logic							req;
	logic							stall;
	pkg_tpu::op_t					op;
	logic [pkg_tpu::DST_W-1:0]		dst;
	logic [W-1:0]					src1, src2, src3;
	logic							busy;
	logic							done;
	logic [pkg_tpu::DST_W-1:0]		wb_dst;
	pkg_tpu::issue_no_t				wb_issue_no;
	logic [W-1:0]					wb_data;

	// Scoreboard by issue number
	logic							exp_set		[N_INO];
	logic [W-1:0]					exp_data	[N_INO];
	logic [pkg_tpu::DST_W-1:0]		exp_dst		[N_INO];
	int								exp_lat		[N_INO];	// 0 skips the latency check
	time							t_acc		[N_INO];
	int								wb_cnt		[N_INO];
	logic [W-1:0]					wb_val		[N_INO];
	logic [pkg_tpu::DST_W-1:0]		wb_dst_s	[N_INO];
	time							t_wb		[N_INO];

	int		seed = 32'h90975962;
	int		errors;
	int		checks;
	int		tests_run;
	int		acc_cnt;		// Accepted commands since reset
	int		issued[$];		// Issue numbers of the running test

	alu #(
		.DEPTH_MLT		(3)
	) dut0 (
		.clock			(clock),
		.rst_n			(rst_n),
		.req			(req),
		.stall			(stall),
		.op				(op),
		.dst			(dst),
		.src1			(src1),
		.src2			(src2),
		.src3			(src3),
		.busy			(busy),
		.done			(done),
		.wb_dst			(wb_dst),
		.wb_issue_no	(wb_issue_no),
		.wb_data		(wb_data)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Watchdog
	initial begin
		#(N_TESTS * 2000 * 4);
		$display("Timeout: the tests did not finish within %0d ns", N_TESTS * 2000 * 4);
		$display("Something failed");
		$finish;
	end

	// Write-back monitor, sampled mid-cycle
	always @(negedge clock) begin
		if (rst_n && done) begin
			if (!exp_set[wb_issue_no]) begin
				$display("ERROR at %0t: write-back of issue number %0d, which was never accepted",
					$time, wb_issue_no);
				errors++;
			end
			wb_val[wb_issue_no]		= wb_data;
			wb_dst_s[wb_issue_no]	= wb_dst;
			t_wb[wb_issue_no]		= $time;
			wb_cnt[wb_issue_no]++;					// Last, so the other fields are in place
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////
	function automatic pkg_tpu::op_t make_op(pkg_tpu::op_type_t t, pkg_tpu::op_class_t c,
			logic s);
		pkg_tpu::op_t o;
		o.op_type	= t;
		o.op_class	= c;
		o.simd		= s;
		return o;
	endfunction

	function automatic logic [W-1:0] ref_result(pkg_tpu::op_t o, logic [W-1:0] a,
			logic [W-1:0] b, logic [W-1:0] c);
		logic [15:0]	hi;
		logic [15:0]	lo;
		logic [4:0]		amt;
		amt = b[4:0];
		ref_result = '0;
		if (o.op_type == pkg_tpu::SHIFT) begin
			case (o.op_class)
				pkg_tpu::SLL:	ref_result = a << amt;
				pkg_tpu::SRL:	ref_result = a >> amt;
				pkg_tpu::SRA:	ref_result = $signed(a) >>> amt;
				default:		ref_result = (a >> amt) | (a << (W - amt));
			endcase
		end else begin
			case (o.op_class)
				pkg_tpu::ADD:		ref_result = a + b;
				pkg_tpu::MULADD: begin
					if (o.simd) begin
						hi = a[31:16] * b[31:16] + c[31:16];	// Lanes wrap on their own
						lo = a[15:0] * b[15:0] + c[15:0];
						ref_result = {hi, lo};
					end else begin
						ref_result = a * b + c;
					end
				end
				pkg_tpu::DIV:		ref_result = (b == 0) ? {W{1'b1}} : a / b;
				default:			ref_result = (b == 0) ? a : a % b;
			endcase
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Driver and checker tasks
	//////////////////////////////////////////////////////////////////////
	task automatic check_eq(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// Called 1 ns after a rising edge and returns at the same point
	task automatic issue_cmd(pkg_tpu::op_t o, logic [pkg_tpu::DST_W-1:0] d, logic [W-1:0] a,
			logic [W-1:0] b, logic [W-1:0] c, int lat, output int ino);
		req		= 1'b1;
		op		= o;
		dst		= d;
		src1	= a;
		src2	= b;
		src3	= c;
		#1;
		while (busy || stall) begin
			@(posedge clock);
			#2;
		end
		@(posedge clock);							// Accepting edge
		ino				= acc_cnt % N_INO;
		acc_cnt++;
		exp_set[ino]	= 1'b1;
		exp_data[ino]	= ref_result(o, a, b, c);
		exp_dst[ino]	= d;
		exp_lat[ino]	= lat;
		t_acc[ino]		= $time;
		wb_cnt[ino]		= 0;
		issued.push_back(ino);
		#1;
		req = 1'b0;
	endtask

	task automatic close_test(string name, int err_start);
		int ino;
		foreach (issued[i])
			while (wb_cnt[issued[i]] == 0)
				@(negedge clock);
		repeat (4) @(negedge clock);				// Catch any repeated write-back
		foreach (issued[i]) begin
			ino = issued[i];
			check_eq($sformatf("done count[%0d]", ino), 1, wb_cnt[ino]);
			check_eq($sformatf("wb_data[%0d]", ino), exp_data[ino], wb_val[ino]);
			check_eq($sformatf("wb_dst[%0d]", ino), exp_dst[ino], wb_dst_s[ino]);
			if (exp_lat[ino] != 0)
				check_eq($sformatf("latency[%0d]", ino), exp_lat[ino],
					32'((t_wb[ino] - t_acc[ino] + 2) / 4));
		end
		issued.delete();
		tests_run++;
		$display("Test %s finished with %0d errors", name, errors - err_start);
		@(posedge clock);
		#1;
	endtask

	task automatic apply_reset();
		rst_n	= 1'b0;
		req		= 1'b0;
		stall	= 1'b0;
		repeat (10) @(posedge clock);
		#1;
		rst_n	= 1'b1;
		acc_cnt	= 0;
		issued.delete();
		for (int i = 0; i < N_INO; i++) begin
			exp_set[i]	= 1'b0;
			wb_cnt[i]	= 0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_ma();
		int				e0;
		int				ino;
		logic [W-1:0]	a, b, c;
		e0 = errors;
		for (int i = 0; i < 24; i++) begin
			a = $random(seed);
			b = $random(seed);
			c = $random(seed);
			case (i % 3)
				0:	issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::ADD, 1'b0), 6'(i), a, b, c, 4, ino);
				1:	issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::MULADD, 1'b0), 6'(i), a, b, c, 4,
						ino);
				default: issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::MULADD, 1'b1), 6'(i), a, b, c,
						4, ino);
			endcase
		end
		close_test("multiply-add", e0);
	endtask

	task automatic test_div();
		int				e0;
		int				ino;
		int				first;
		logic [W-1:0]	a, b;
		pkg_tpu::op_t	o_div;
		e0		= errors;
		o_div	= make_op(pkg_tpu::ARITH, pkg_tpu::DIV, 1'b0);
		for (int i = 0; i < 6; i++) begin
			a = $random(seed);
			b = (i < 3) ? $random(seed) : ($random(seed) & 32'h0000_0fff);	// Small divisors too
			issue_cmd(make_op(pkg_tpu::ARITH, (i % 2) ? pkg_tpu::REM : pkg_tpu::DIV, 1'b0),
				6'(i), a, b, 0, 33, ino);
		end
		a = $random(seed);
		issue_cmd(o_div, 6'd10, a, 0, 0, 33, ino);
		issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::REM, 1'b0), 6'd11, a, 0, 0, 33, ino);

		// A second DIV waits for the first write-back
		issue_cmd(o_div, 6'd12, 32'd1000, 32'd7, 0, 33, first);
		req		= 1'b1;
		op		= o_div;
		src1	= $random(seed);
		src2	= 32'd13;
		do begin
			@(negedge clock);
			check_eq("busy", 1, busy);
		end while (!done);
		check_eq("wb_issue_no", first, wb_issue_no);
		@(posedge clock);
		#1;
		issue_cmd(o_div, 6'd13, src1, src2, 0, 33, ino);
		close_test("divide", e0);
	endtask

	task automatic test_shift();
		int				e0;
		int				ino;
		logic [W-1:0]	a, b;
		e0 = errors;
		for (int i = 0; i < 16; i++) begin
			a = $random(seed);
			b = $random(seed);						// Only the low 5 bits count
			issue_cmd(make_op(pkg_tpu::SHIFT, pkg_tpu::op_class_t'(i % 4), 1'b0), 6'(i), a, b, 0,
				1, ino);
		end
		issue_cmd(make_op(pkg_tpu::SHIFT, pkg_tpu::ROR, 1'b0), 6'd20, 32'h8000_0001, 0, 0, 1, ino);
		issue_cmd(make_op(pkg_tpu::SHIFT, pkg_tpu::SRA, 1'b0), 6'd21, 32'h8000_0000, 31, 0, 1,
			ino);
		close_test("shift", e0);
	endtask

	task automatic test_order();
		int		e0;
		int		i_ma, i_sll, i_div, i_add;
		e0 = errors;
		issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::MULADD, 1'b0), 6'd1, $random(seed),
			$random(seed), $random(seed), 4, i_ma);
		repeat (2) @(posedge clock);
		#1;
		// Both results valid together, the SLL waits one cycle
		issue_cmd(make_op(pkg_tpu::SHIFT, pkg_tpu::SLL, 1'b0), 6'd2, $random(seed), 5, 0, 2, i_sll);
		issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::DIV, 1'b0), 6'd3, $random(seed), 3, 0, 33,
			i_div);
		issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::ADD, 1'b0), 6'd4, $random(seed),
			$random(seed), 0, 4, i_add);
		while (wb_cnt[i_div] == 0)
			@(negedge clock);
		check_eq("SLL write-back time", 32'(t_wb[i_ma] + 4), 32'(t_wb[i_sll]));
		check_eq("ADD before DIV", 1, t_wb[i_add] < t_wb[i_div]);
		close_test("oldest-first", e0);
	endtask

	task automatic test_stall();
		int		e0;
		int		ino;
		e0 = errors;
		for (int i = 0; i < 3; i++)
			issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::ADD, 1'b0), 6'(i), $random(seed),
				$random(seed), 0, 4, ino);
		stall	= 1'b1;
		req		= 1'b1;								// Held off by the stall
		repeat (8) @(posedge clock);
		#1;
		foreach (issued[i])
			check_eq($sformatf("drained during stall[%0d]", issued[i]), 1, wb_cnt[issued[i]]);
		req		= 1'b0;
		stall	= 1'b0;
		issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::ADD, 1'b0), 6'd9, $random(seed),
			$random(seed), 0, 4, ino);
		close_test("stall", e0);
	endtask

	task automatic test_reset();
		int		e0;
		int		ino;
		e0 = errors;
		// Result in flight at reset must never appear
		issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::MULADD, 1'b0), 6'd5, $random(seed),
			$random(seed), $random(seed), 4, ino);
		apply_reset();
		#1;
		check_eq("done", 0, done);
		check_eq("busy", 0, busy);
		@(posedge clock);
		#1;
		issue_cmd(make_op(pkg_tpu::ARITH, pkg_tpu::ADD, 1'b0), 6'd6, $random(seed),
			$random(seed), 0, 4, ino);
		while (!done)
			@(negedge clock);
		check_eq("first issue number", 0, wb_issue_no);
		close_test("reset", e0);
	endtask

	initial begin
		rst_n		= 1'b0;
		req			= 1'b0;
		stall		= 1'b0;
		op			= make_op(pkg_tpu::ARITH, pkg_tpu::ADD, 1'b0);
		dst			= '0;
		src1		= '0;
		src2		= '0;
		src3		= '0;
		errors		= 0;
		checks		= 0;
		tests_run	= 0;
		apply_reset();
		test_ma();
		test_div();
		test_shift();
		test_order();
		test_stall();
		test_reset();
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
